/* src/bn_pkg.sv */
package bn_pkg;

  // activation format, signed Q4.12
  localparam int word_width = 16;
  // fractional bits, same in both formats
  localparam int frac_bits = 12;
  // parameters and intermediates, signed Q9.12
  localparam int mem_width = 21;

  // channels walked per pass
  localparam int num_channels = 8;
  localparam int chan_width = $clog2(num_channels);

  // parameter file, one packed word per channel
  localparam string param_file = "bn_params.mem";

  typedef logic signed [word_width-1:0] act_t;
  typedef logic signed [mem_width-1:0] wide_t;
  typedef logic [chan_width-1:0] chan_t;
  // mean, inv_var, scale, offset from the top bits down
  typedef logic [4*mem_width-1:0] rom_word_t;

  // saturation limits
  localparam act_t act_max = {1'b0, {(word_width-1){1'b1}}};
  localparam act_t act_min = {1'b1, {(word_width-1){1'b0}}};
  localparam wide_t wide_max = {1'b0, {(mem_width-1){1'b1}}};
  localparam wide_t wide_min = {1'b1, {(mem_width-1){1'b0}}};

  // arithmetic unit operation select
  typedef logic [1:0] alu_op_t;
  localparam alu_op_t alu_add = 2'd0;
  localparam alu_op_t alu_sub = 2'd1;
  // multiply, result rescaled by frac_bits
  localparam alu_op_t alu_mul = 2'd2;

endpackage

/* src/sat_alu.sv */
`timescale 1ns/100ps

module sat_alu
  import bn_pkg::*;
(
  // operation, tied off per instance
  input  alu_op_t op_i,
  // operands, both Q9.12
  input  wide_t   a_i,
  input  wide_t   b_i,
  // saturated result, Q9.12
  output wide_t   data_o
);

  // full precision product, Q18.24
  logic signed [2*mem_width-1:0] product;
  // exact result before saturation
  logic signed [2*mem_width-1:0] exact;

  // operands sign-extend to the product width
  assign product = a_i * b_i;

  // pick the exact result for the selected op
  always_comb begin
    case (op_i)
      alu_add: begin
        // cannot overflow the wide container
        exact = a_i + b_i;
      end
      alu_sub: begin
        exact = a_i - b_i;
      end
      alu_mul: begin
        // back to Q.12, rounds toward minus infinity
        exact = product >>> frac_bits;
      end
      default: begin
        // unused code, pass a through
        exact = a_i;
      end
    endcase
  end

  // clamp to the representable Q9.12 range
  always_comb begin
    if (exact > wide_max) begin
      // positive overflow
      data_o = wide_max;
    end else if (exact < wide_min) begin
      // negative overflow
      data_o = wide_min;
    end else begin
      // in range, low bits carry the value
      data_o = exact[mem_width-1:0];
    end
  end

endmodule

/* src/param_rom.sv */
`timescale 1ns/100ps

module param_rom
  import bn_pkg::*;
(
  input  logic      clk_i,
  // channel of the next accepted input
  input  chan_t     addr_i,
  // packed parameters, one cycle after addr_i
  output rom_word_t data_o
);

  // one packed word per channel
  rom_word_t rom_mem [0:num_channels-1];

  // contents fixed at elaboration
  initial begin
    $readmemh(param_file, rom_mem);
  end

  // registered read, no reset on the data path
  always_ff @(posedge clk_i) begin
    data_o <= rom_mem[addr_i];
  end

  // address must be a known channel every clock
  addr_known_a : assert property (
    @(posedge clk_i) !$isunknown(addr_i)
  ) else $error("param_rom address unknown");

endmodule

/* src/single_fifo_ctrl.sv */
`timescale 1ns/100ps

module single_fifo_ctrl (
  input  logic clk_i,
  input  logic reset_i,
  // producer side
  input  logic valid_i,
  output logic ready_o,
  // consumer side
  output logic valid_o,
  input  logic ready_i,
  // loads the output register
  output logic en_o
);

  // the single entry is occupied
  logic full_r;

  // full bit drives the consumer valid
  assign valid_o = full_r;

  // room when empty or when the held word leaves now
  assign ready_o = ~full_r | ready_i;

  // an input transfer this cycle
  assign en_o = valid_i & ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_r <= 1'b0;
    end else if (en_o) begin
      // new word replaces or fills the entry
      full_r <= 1'b1;
    end else if (ready_i) begin
      // drained with nothing arriving
      full_r <= 1'b0;
    end
  end

  // held word is never dropped under back-pressure
  valid_hold_a : assert property (
    @(posedge clk_i) disable iff (reset_i)
    valid_o && !ready_i |=> valid_o
  ) else $error("valid_o fell while ready_i was low");

  // producer keeps its word offered until it is taken
  producer_hold_a : assert property (
    @(posedge clk_i) disable iff (reset_i)
    valid_i && !ready_o |=> valid_i
  ) else $error("valid_i fell before the word was accepted");

endmodule

/* src/bn_layer.sv */
`timescale 1ns/100ps

module bn_layer
  import bn_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  // producer side
  input  logic valid_i,
  output logic ready_o,
  input  act_t data_i,
  // consumer side
  output logic valid_o,
  input  logic ready_i,
  output act_t data_o
);

  // input transfer, loads data_o and steps the channel
  logic en;

  // channel counter, current and next
  chan_t count_r;
  chan_t count_n;

  // packed ROM word and its fields
  rom_word_t rom_word;
  wide_t mean;
  wide_t inv_var;
  wide_t scale;
  wide_t offset;

  // arithmetic chain stages
  wide_t data_ext;
  wide_t centered;
  wide_t normed;
  wide_t scaled;
  wide_t shifted;

  // result clamped to the activation range
  act_t data_sat;

  // handshake control, one entry deep
  single_fifo_ctrl i_ctrl (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .valid_o (valid_o),
    .ready_i (ready_i),
    .en_o    (en)
  );

  // next channel
  // reset forces 0 here so the ROM reloads word 0 too
  always_comb begin
    if (reset_i) begin
      count_n = '0;
    end else if (en) begin
      if (count_r == chan_t'(num_channels - 1)) begin
        // wrap after the last channel
        count_n = '0;
      end else begin
        count_n = count_r + 1'b1;
      end
    end else begin
      count_n = count_r;
    end
  end

  always_ff @(posedge clk_i) begin
    count_r <= count_n;
  end

  // addressed with count_n, so the word matches count_r
  param_rom i_rom (
    .clk_i  (clk_i),
    .addr_i (count_n),
    .data_o (rom_word)
  );

  // unpack, mean in the top field
  assign {mean, inv_var, scale, offset} = rom_word;

  // Q4.12 into Q9.12
  assign data_ext = wide_t'(data_i);

  // x - mean
  sat_alu i_sub_mean (
    .op_i   (alu_sub),
    .a_i    (data_ext),
    .b_i    (mean),
    .data_o (centered)
  );

  // times 1/sqrt(var)
  sat_alu i_mul_var (
    .op_i   (alu_mul),
    .a_i    (centered),
    .b_i    (inv_var),
    .data_o (normed)
  );

  // times gamma
  sat_alu i_mul_scale (
    .op_i   (alu_mul),
    .a_i    (normed),
    .b_i    (scale),
    .data_o (scaled)
  );

  // plus beta
  sat_alu i_add_offset (
    .op_i   (alu_add),
    .a_i    (scaled),
    .b_i    (offset),
    .data_o (shifted)
  );

  // clamp Q9.12 down to Q4.12
  always_comb begin
    if (shifted > act_max) begin
      data_sat = act_max;
    end else if (shifted < act_min) begin
      data_sat = act_min;
    end else begin
      data_sat = shifted[word_width-1:0];
    end
  end

  // output register, holds under back-pressure
  always_ff @(posedge clk_i) begin
    if (en) begin
      data_o <= data_sat;
    end
  end

  // held output word stays put while the consumer stalls
  data_hold_a : assert property (
    @(posedge clk_i) disable iff (reset_i)
    valid_o && !ready_i |=> $stable(data_o)
  ) else $error("data_o changed while ready_i was low");

endmodule

/* tests/tb_bn_layer.sv */
`timescale 1ns/100ps

module tb_bn_layer
  import bn_pkg::*;
();

  logic clk_i;
  logic reset_i;
  logic valid_i;
  logic ready_o;
  act_t data_i;
  logic valid_o;
  logic ready_i;
  act_t data_o;

  // model copy of the parameter table
  rom_word_t model_rom [0:num_channels-1];
  // channel of the next accepted input
  chan_t model_chan;
  // words accepted but not yet delivered
  act_t expected_q[$];
  chan_t chan_q[$];

  int error_count;
  int in_count;
  int out_count;
  int words_left;
  int stall_cycles;
  int sat_max_seen;
  int sat_min_seen;
  int hold_seen;
  bit timeout_hit;
  bit in_xfer;
  bit out_xfer;
  bit hold_check;
  act_t held_data;

  bn_layer i_bn_layer (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .data_i  (data_i),
    .valid_o (valid_o),
    .ready_i (ready_i),
    .data_o  (data_o)
  );

  // 20 ns period
  always #10 clk_i = ~clk_i;

  function automatic longint clamp_range(input longint value, input longint lo,
                                         input longint hi);
    if (value > hi) begin
      return hi;
    end else if (value < lo) begin
      return lo;
    end
    return value;
  endfunction

  // expected output of one activation on one channel
  function automatic act_t predict(input act_t x, input chan_t ch);
    rom_word_t word;
    wide_t f_mean;
    wide_t f_inv;
    wide_t f_scale;
    wide_t f_offset;
    longint wide_hi;
    longint wide_lo;
    longint act_hi;
    longint act_lo;
    longint v;
    word = model_rom[ch];
    f_mean = word[4*mem_width-1 -: mem_width];
    f_inv = word[3*mem_width-1 -: mem_width];
    f_scale = word[2*mem_width-1 -: mem_width];
    f_offset = word[mem_width-1:0];
    wide_hi = (longint'(1) << (mem_width - 1)) - 1;
    wide_lo = -(longint'(1) << (mem_width - 1));
    act_hi = (longint'(1) << (word_width - 1)) - 1;
    act_lo = -(longint'(1) << (word_width - 1));
    // every stage clamps to the Q9.12 range
    v = clamp_range(longint'(x) - longint'(f_mean), wide_lo, wide_hi);
    // products drop 12 fraction bits, floor rounding
    v = clamp_range((v * longint'(f_inv)) >>> frac_bits, wide_lo, wide_hi);
    v = clamp_range((v * longint'(f_scale)) >>> frac_bits, wide_lo, wide_hi);
    v = clamp_range(v + longint'(f_offset), wide_lo, wide_hi);
    // down to Q4.12
    v = clamp_range(v, act_lo, act_hi);
    return act_t'(v);
  endfunction

  // mostly random, with a share near both extremes
  function automatic act_t random_activation();
    int unsigned pick;
    pick = $urandom_range(0, 7);
    if (pick == 0) begin
      return act_t'(32'h7fff - $urandom_range(0, 15));
    end else if (pick == 1) begin
      return act_t'(32'h8000 + $urandom_range(0, 15));
    end
    return act_t'($urandom);
  endfunction

  task automatic report_timeout(input string what);
    $display("timeout: %s", what);
    error_count++;
    timeout_hit = 1'b1;
  endtask

  // checks and model update, before the rising edge
  task automatic check_cycle(input bit stream_mode);
    act_t expect_val;
    chan_t expect_chan;
    in_xfer = valid_i && ready_o;
    out_xfer = valid_o && ready_i;
    // a held word keeps valid_o and its value
    if (hold_check) begin
      hold_seen++;
      if (valid_o !== 1'b1) begin
        $display("** Error valid_o under back-pressure: expected %h, got %h", 1'b1, valid_o);
        error_count++;
      end
      if (data_o !== held_data) begin
        $display("** Error data_o under back-pressure: expected %h, got %h",
                 held_data, data_o);
        error_count++;
      end
    end
    // valid_o tracks the single held entry
    if (valid_o !== (expected_q.size() != 0)) begin
      $display("** Error valid_o: expected %h, got %h", expected_q.size() != 0, valid_o);
      error_count++;
    end
    if (expected_q.size() > 1) begin
      $display("stage accepted a second word while one was still held");
      error_count++;
    end
    // streaming must accept every cycle
    if (stream_mode && valid_i && ready_o !== 1'b1) begin
      $display("** Error ready_o while streaming: expected %h, got %h", 1'b1, ready_o);
      error_count++;
    end
    if (out_xfer) begin
      out_count++;
      if (expected_q.size() == 0) begin
        $display("output transfer with no accepted word behind it");
        error_count++;
      end else begin
        expect_val = expected_q.pop_front();
        expect_chan = chan_q.pop_front();
        if (data_o !== expect_val) begin
          $display("** Error data_o: expected %h, got %h, channel %0d",
                   expect_val, data_o, expect_chan);
          error_count++;
        end else if (expect_val == act_t'(16'h7fff)) begin
          sat_max_seen++;
        end else if (expect_val == act_t'(16'h8000)) begin
          sat_min_seen++;
        end
      end
    end
    if (in_xfer) begin
      in_count++;
      expected_q.push_back(predict(data_i, model_chan));
      chan_q.push_back(model_chan);
      // wrap after the last channel
      if (model_chan == chan_t'(num_channels - 1)) begin
        model_chan = '0;
      end else begin
        model_chan = model_chan + 1'b1;
      end
    end
    hold_check = valid_o && !ready_i;
    held_data = data_o;
  endtask

  // drive on the falling edge, sample 5 ns later
  task automatic clock_cycle(input bit stream_mode);
    @(negedge clk_i);
    if (valid_i && !in_xfer) begin
      // word not taken yet, keep it
      stall_cycles++;
      if (stall_cycles > 64) begin
        report_timeout("input word not accepted within 64 cycles");
      end
    end else if (words_left > 0 && (stream_mode || $urandom_range(0, 3) != 0)) begin
      valid_i = 1'b1;
      data_i = random_activation();
      words_left--;
      stall_cycles = 0;
    end else begin
      // idle, data is junk
      valid_i = 1'b0;
      data_i = act_t'($urandom);
    end
    ready_i = stream_mode ? 1'b1 : ($urandom_range(0, 1) == 1);
    #5;
    check_cycle(stream_mode);
  endtask

  task automatic run_traffic(input int words, input bit stream_mode, input int max_cycles);
    int cycles;
    cycles = 0;
    words_left = words;
    while ((words_left > 0 || valid_i) && !timeout_hit) begin
      clock_cycle(stream_mode);
      cycles++;
      if (cycles >= max_cycles && !timeout_hit) begin
        report_timeout("traffic phase did not finish in time");
      end
    end
  endtask

  task automatic drain_stage(input int max_cycles);
    int cycles;
    cycles = 0;
    while (expected_q.size() != 0 && !timeout_hit) begin
      clock_cycle(1'b0);
      cycles++;
      if (cycles >= max_cycles && expected_q.size() != 0) begin
        report_timeout("held word was not delivered");
      end
    end
  endtask

  initial begin
    int in_start;
    int out_start;
    int held;
    void'($urandom(95));
    $readmemh(param_file, model_rom);
    clk_i = 1'b0;
    reset_i = 1'b1;
    valid_i = 1'b0;
    ready_i = 1'b0;
    data_i = '0;
    model_chan = '0;
    error_count = 0;
    in_count = 0;
    out_count = 0;
    words_left = 0;
    stall_cycles = 0;
    sat_max_seen = 0;
    sat_min_seen = 0;
    hold_seen = 0;
    timeout_hit = 1'b0;
    in_xfer = 1'b0;
    out_xfer = 1'b0;
    hold_check = 1'b0;
    held_data = '0;
    repeat (16) @(negedge clk_i);
    reset_i = 1'b0;
    #5;
    // idle and ready straight out of reset
    if (valid_o !== 1'b0) begin
      $display("** Error valid_o after reset: expected %h, got %h", 1'b0, valid_o);
      error_count++;
    end
    if (ready_o !== 1'b1) begin
      $display("** Error ready_o after reset: expected %h, got %h", 1'b1, ready_o);
      error_count++;
    end
    // random producer and consumer, many channel wraps
    run_traffic(300, 1'b0, 4000);
    drain_stage(200);
    // back-to-back transfers with both sides held high
    in_start = in_count;
    out_start = out_count;
    if (!timeout_hit) begin
      run_traffic(48, 1'b1, 200);
    end
    held = (in_count - in_start) - (out_count - out_start);
    // after the last edge the stage holds exactly the unmatched words
    @(posedge clk_i);
    #1;
    if (held > 1) begin
      $display("streaming left %0d words held, at most one fits", held);
      error_count++;
    end else if (valid_o !== (held == 1)) begin
      $display("** Error valid_o after streaming: expected %h, got %h", held == 1, valid_o);
      error_count++;
    end
    drain_stage(200);
    if (sat_max_seen == 0 || sat_min_seen == 0) begin
      $display("saturation not reached, %0d at max, %0d at min", sat_max_seen, sat_min_seen);
      error_count++;
    end
    if (hold_seen == 0) begin
      $display("consumer never applied back-pressure");
      error_count++;
    end
    $display("errors %0d, inputs %0d, outputs %0d", error_count, in_count, out_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* bn_params.mem */
// one word per channel, 21 hex digits = 4 fields of 21 bits
// fields from the top: mean, inv_var, scale, offset, all signed Q9.12
// ch0 identity
000000040000200000000
// ch1 mean 0.5, inv_var 2.0, scale 1.0, offset 0.25
004000080000200000400
// ch2 gain 16, saturates near both input extremes
000000100000800000000
// ch3 mean -1.0, inv_var 0.5, scale -2.0, offset 0.125
FF800002003FC00000200
// ch4 mean 0.25, inv_var 1.5, scale 0.75, offset -0.5
0020000600001801FF800
// ch5 gain 64, overflows the wide range as well
000000200001000000000
// ch6 mean 2.0, inv_var 1.0, scale 1.0, offset 3.0
010000040000200003000
// ch7 negation, most negative input clamps to the top
00000004003FE00000000

/* build.f */
src/bn_pkg.sv
src/sat_alu.sv
src/param_rom.sv
src/single_fifo_ctrl.sv
src/bn_layer.sv
tests/tb_bn_layer.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_bn_layer
out=$(./obj_dir/Vtb_bn_layer)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "Testbench passed"
